//--- Makefile
# Verilator simulation of the memory controller

VERILATOR ?= verilator
TOP       ?= tb_mem_ctrl
FILELIST  ?= mem_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/mem_ctrl_assert.sv
////////////////////////////////////////////////////////////////////////////
// Bus protocol assertions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_ctrl_assert
(
   input logic bus_clk,
   input logic rst,
   input logic req_valid,
   input logic req_rw,
   input logic wr_valid,
   input logic ack,
   input logic bg,
   input logic br,
   input logic dest_ic,
   input logic dest_dc,
   input logic rd_valid
);

   logic       reset_bad = 1'b0;
   logic       ack_bad   = 1'b0;
   logic       br_bad    = 1'b0;
   logic       grant_bad = 1'b0;
   logic       beats_bad = 1'b0;
   logic       dest_bad  = 1'b0;
   logic       failed;
   logic [1:0] beats_seen;

   // Set once any assertion below has failed
   assign failed = reset_bad | ack_bad | br_bad | grant_bad | beats_bad | dest_bad;

   // Write beats seen since the last write request
   always_ff @(posedge bus_clk)
   begin
      if (rst)
         beats_seen <= '0;
      else if (req_valid && req_rw)
         beats_seen <= '0;
      else if (wr_valid)
         beats_seen <= beats_seen + 1'b1;
   end

   // Outputs are quiet in the cycle after a reset edge
   reset_quiet: assert property (@(posedge bus_clk)
      rst |=> !ack && !br && !rd_valid && !dest_ic && !dest_dc)
   else
   begin
      $error("ack, br, rd_valid or a dest strobe high after reset");
      reset_bad = 1'b1;
   end

   // An ack answers a read request or the fourth write beat
   ack_cause: assert property (@(posedge bus_clk) disable iff (rst)
      ack |-> $past(req_valid && !req_rw) || $past(wr_valid && (beats_seen == 2'd3)))
   else
   begin
      $error("ack without a read request or fourth write beat one cycle earlier");
      ack_bad = 1'b1;
   end

   // Bus request held until the arbiter grants
   br_hold: assert property (@(posedge bus_clk) disable iff (rst)
      br && !bg |=> br)
   else
   begin
      $error("br dropped before bg");
      br_bad = 1'b1;
   end

   grant_first: assert property (@(posedge bus_clk) disable iff (rst)
      $rose(rd_valid) |-> $past(br) && $past(bg) && !br)
   else
   begin
      $error("rd_valid rose without br and bg in the cycle before");
      grant_bad = 1'b1;
   end

   four_beats: assert property (@(posedge bus_clk) disable iff (rst)
      $rose(rd_valid) |-> rd_valid ##1 rd_valid ##1 rd_valid ##1 rd_valid ##1 !rd_valid)
   else
   begin
      $error("Return was not exactly four consecutive beats");
      beats_bad = 1'b1;
   end

   // One strobe at a time and only while data is on the bus
   dest_onehot: assert property (@(posedge bus_clk) disable iff (rst)
      (dest_ic || dest_dc) |-> rd_valid && !(dest_ic && dest_dc))
   else
   begin
      $error("dest strobe outside rd_valid or both strobes high");
      dest_bad = 1'b1;
   end

endmodule

bind mem_ctrl mem_ctrl_assert mem_ctrl_assert_i
(
   .bus_clk   (bus_clk),
   .rst       (rst),
   .req_valid (req_valid),
   .req_rw    (req_rw),
   .wr_valid  (wr_valid),
   .ack       (ack),
   .bg        (bg),
   .br        (br),
   .dest_ic   (dest_ic),
   .dest_dc   (dest_dc),
   .rd_valid  (rd_valid)
);

//--- bench/tb_mem_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Memory controller testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_mem_ctrl
   import mem_bus_pkg::*;
();

   localparam int mem_latency = 4;
   localparam int bank_rows   = 64;
   localparam int mem_bytes   = bank_rows * 32;
   localparam int n_lines     = 6;
   localparam int n_partial   = 16;
   // Fill and check per line, write and read per update, then the retry pair
   localparam int n_trans     = 3 * n_lines + 2 * n_partial + 2;
   localparam int max_cycles  = 40 * n_trans + 2;

   logic        bus_clk;
   logic        rst;
   logic        req_valid;
   logic [15:0] req_addr;
   logic [2:0]  req_size;
   logic        req_rw;
   bus_src_t    req_src;
   logic        wr_valid;
   bus_word_t   wr_data;
   logic        bg;
   logic        ack;
   logic        br;
   logic        dest_ic;
   logic        dest_dc;
   logic        rd_valid;
   bus_word_t   rd_data;

   logic [7:0]  model [mem_bytes];
   logic [15:0] line_addr [n_lines];
   int          cycles = 0;

   mem_ctrl #(
      .mem_latency (mem_latency),
      .bank_rows   (bank_rows)
   ) mem_ctrl_i (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_size  (req_size),
      .req_rw    (req_rw),
      .req_src   (req_src),
      .wr_valid  (wr_valid),
      .wr_data   (wr_data),
      .bg        (bg),
      .ack       (ack),
      .br        (br),
      .dest_ic   (dest_ic),
      .dest_dc   (dest_dc),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data)
   );

   initial
   begin
      bus_clk = 1'b0;
      forever
         #50 bus_clk = ~bus_clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic mismatch_stop(input string name, input bus_word_t got, input bus_word_t want);
      $display("** Error: %s = %h, expected %h", name, got, want);
      $display("Checks failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   function automatic bus_src_t pick_src();
      return bus_src_t'($urandom_range(1, 0));
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Arbiter, grants after 0 to 5 cycles
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      int delay;
      bg = 1'b0;
      forever
      begin
         @(negedge bus_clk);
         if (br && !bg)
         begin
            delay = $urandom_range(5, 0);
            repeat (delay)
               @(negedge bus_clk);
            bg = 1'b1;
            @(negedge bus_clk);
            bg = 1'b0;
         end
      end
   end

   always @(negedge bus_clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
         abort_run($sformatf("Timeout, run still busy after %0d cycles", max_cycles));
      else if (mem_ctrl_i.mem_ctrl_assert_i.failed)
         abort_run("A bound protocol assertion failed");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus master tasks
   ////////////////////////////////////////////////////////////////////////////

   // Optionally slips a read in on the first beat, while the latch is busy
   task automatic write_bytes(input logic [15:0] addr, input logic [2:0] size,
                              input bus_src_t src, input logic [63:0] data, input bit intrude);
      bus_word_t beats [line_beats];
      logic      got_ack;
      int        base;
      int        off;
      beats[0] = data[31:0];
      beats[1] = data[63:32];
      // Filler that the size mask must keep out of memory
      beats[2] = $urandom;
      beats[3] = $urandom;
      got_ack  = 1'b0;
      while (!got_ack)
      begin
         req_valid = 1'b1;
         req_addr  = addr;
         req_size  = size;
         req_rw    = 1'b1;
         req_src   = src;
         @(negedge bus_clk);
         req_valid = 1'b0;
         for (int b = 0; b < line_beats; b++)
         begin
            wr_valid = 1'b1;
            wr_data  = beats[b];
            if (intrude && b == 0)
            begin
               req_valid = 1'b1;
               req_rw    = 1'b0;
               req_src   = src_dc;
            end
            @(negedge bus_clk);
            req_valid = 1'b0;
            if (intrude && b == 0)
               assert (!ack) else abort_run("Read sent into a full write latch got an ack");
         end
         wr_valid = 1'b0;
         got_ack  = ack;
      end
      // Bytes past the end of the line are lost
      base = int'({addr[15:4], 4'h0}) % mem_bytes;
      off  = int'(addr[3:0]);
      for (int i = 0; i <= int'(size); i++)
      begin
         if (off + i < 16)
            model[base + off + i] = data[8*i +: 8];
      end
   endtask

   task automatic read_line(input logic [15:0] addr, input bus_src_t src);
      logic      got_ack;
      int        base;
      bus_word_t want;
      got_ack = 1'b0;
      // Dropped requests are sent again
      while (!got_ack)
      begin
         req_valid = 1'b1;
         req_addr  = addr;
         req_size  = 3'd0;
         req_rw    = 1'b0;
         req_src   = src;
         @(negedge bus_clk);
         req_valid = 1'b0;
         got_ack   = ack;
      end
      while (!rd_valid)
         @(negedge bus_clk);
      base = int'({addr[15:4], 4'h0}) % mem_bytes;
      for (int w = 0; w < line_beats; w++)
      begin
         want = {model[base + 4*w + 3], model[base + 4*w + 2],
                 model[base + 4*w + 1], model[base + 4*w]};
         assert (rd_valid) else abort_run("rd_valid dropped before the fourth beat");
         assert (rd_data === want) else mismatch_stop("rd_data", rd_data, want);
         assert (dest_ic === (src == src_ic))
            else mismatch_stop("dest_ic", 32'(dest_ic), 32'(src == src_ic));
         assert (dest_dc === (src == src_dc))
            else mismatch_stop("dest_dc", 32'(dest_dc), 32'(src == src_dc));
         @(negedge bus_clk);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(18));
      rst       = 1'b1;
      req_valid = 1'b0;
      req_addr  = '0;
      req_size  = '0;
      req_rw    = 1'b0;
      req_src   = src_ic;
      wr_valid  = 1'b0;
      wr_data   = '0;
      repeat (2)
         @(negedge bus_clk);
      rst = 1'b0;

      // Odd and even line numbers land in both halves of a row
      for (int n = 0; n < n_lines; n++)
      begin
         line_addr[n] = 16'((n * 7 + 3) * 16);
         write_bytes(line_addr[n], 3'd7, pick_src(), {$urandom, $urandom}, 1'b0);
         write_bytes(line_addr[n] + 16'd8, 3'd7, pick_src(), {$urandom, $urandom}, 1'b0);
         read_line(line_addr[n], pick_src());
      end

      // Partial writes of random size and offset
      for (int p = 0; p < n_partial; p++)
      begin
         write_bytes(line_addr[p % n_lines] | 16'($urandom_range(15, 0)),
                     3'($urandom_range(7, 0)), pick_src(), {$urandom, $urandom}, 1'b0);
         read_line(line_addr[p % n_lines] | 16'($urandom_range(15, 0)), pick_src());
      end

      // Read dropped during write collection, then retried
      write_bytes(line_addr[0] | 16'd5, 3'd3, src_ic, {$urandom, $urandom}, 1'b1);
      read_line(line_addr[0] | 16'd5, src_dc);

      repeat (2)
         @(negedge bus_clk);
      if (mem_ctrl_i.mem_ctrl_assert_i.failed)
         abort_run("A bound protocol assertion failed");
      else
      begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

//--- mem_ctrl.f
source/mem_bus_pkg.sv
source/mem_store_pkg.sv
source/mem_ctrl_if.sv
source/bus_req_decode.sv
source/mem_bank.sv
source/mem_access_exec.sv
source/bus_reply_result.sv
source/mem_ctrl.sv
bench/mem_ctrl_assert.sv
bench/tb_mem_ctrl.sv

//--- source/bus_reply_result.sv
////////////////////////////////////////////////////////////////////////////
// Read line return over the bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module bus_reply_result
   import mem_bus_pkg::*, mem_store_pkg::*;
(
   input  logic      bus_clk,
   input  logic      rst,
   mem_line_if.dst   line,
   input  logic      bg,
   output logic      br,
   output logic      dest_ic,
   output logic      dest_dc,
   output logic      rd_valid,
   output bus_word_t rd_data
);

   localparam int beat_w = $clog2(line_beats);
   localparam int word_w = $bits(bus_word_t);

   typedef enum logic [1:0]
   {
      st_idle,
      st_request,
      st_send
   } reply_state_t;

   reply_state_t      state;
   mem_line_t         hold_line;
   bus_src_t          hold_src;
   logic [beat_w-1:0] beat;

   // A new line is only taken when the bus side is idle
   assign line.take = (state == st_idle);

   ////////////////////////////////////////////////////////////////////////////
   // Reply FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         state <= st_idle;
         beat  <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (line.valid)
                  state <= st_request;
            end
            // Bus request stays up until the arbiter grants
            st_request:
            begin
               beat <= '0;
               if (bg)
                  state <= st_send;
            end
            st_send:
            begin
               beat <= beat + 1'b1;
               if (beat == beat_w'(line_beats - 1))
                  state <= st_idle;
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (line.valid && line.take)
      begin
         hold_line <= line.line;
         hold_src  <= line.src_code;
      end
   end

   // Strobe follows the requester for all four beats
   assign br       = (state == st_request);
   assign rd_valid = (state == st_send);
   assign dest_ic  = rd_valid && (hold_src == src_ic);
   assign dest_dc  = rd_valid && (hold_src == src_dc);
   assign rd_data  = hold_line[beat*word_w +: word_w];

endmodule

//--- source/bus_req_decode.sv
////////////////////////////////////////////////////////////////////////////
// Bus request decode and write latch
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module bus_req_decode
   import mem_bus_pkg::*, mem_store_pkg::*;
(
   input  logic        bus_clk,
   input  logic        rst,
   input  logic        req_valid,
   input  logic [15:0] req_addr,
   input  logic [2:0]  req_size,
   input  logic        req_rw,
   input  bus_src_t    req_src,
   input  logic        wr_valid,
   input  bus_word_t   wr_data,
   output logic        ack,
   mem_req_if.src      req
);

   localparam int beat_w = $clog2(line_beats);
   localparam int word_w = $bits(bus_word_t);

   bus_req_t          latch_req;
   mem_line_t         latch_data;
   logic              latch_valid;
   logic              collecting;
   logic [beat_w-1:0] beat_cnt;
   logic              latch_free;
   logic              last_beat;

   // Latch counts as full while it still waits for write beats
   assign latch_free = !latch_valid && !collecting;
   assign last_beat  = collecting && wr_valid && (beat_cnt == beat_w'(line_beats - 1));

   ////////////////////////////////////////////////////////////////////////////
   // Latch control
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         latch_valid <= 1'b0;
         collecting  <= 1'b0;
         beat_cnt    <= '0;
         ack         <= 1'b0;
      end
      else
      begin
         ack <= 1'b0;
         // Execute picked up the latch
         if (latch_valid && req.take)
            latch_valid <= 1'b0;
         // A request hitting a busy latch is simply ignored
         if (req_valid && latch_free)
         begin
            if (req_rw)
            begin
               collecting <= 1'b1;
               beat_cnt   <= '0;
            end
            else
            begin
               latch_valid <= 1'b1;
               ack         <= 1'b1;
            end
         end
         if (collecting && wr_valid)
            beat_cnt <= beat_cnt + 1'b1;
         // Write is complete once the fourth beat lands
         if (last_beat)
         begin
            collecting  <= 1'b0;
            latch_valid <= 1'b1;
            ack         <= 1'b1;
         end
      end
   end

   // Request fields and line data
   always_ff @(posedge bus_clk)
   begin
      if (req_valid && latch_free)
      begin
         latch_req.addr <= req_addr;
         latch_req.size <= req_size;
         latch_req.rw   <= req_rw;
         latch_req.src  <= req_src;
      end
      // Beat n goes to word n of the line
      if (collecting && wr_valid)
         latch_data[beat_cnt*word_w +: word_w] <= wr_data;
   end

   assign req.valid = latch_valid;
   assign req.req   = latch_req;
   assign req.data  = latch_data;

endmodule

//--- source/mem_access_exec.sv
////////////////////////////////////////////////////////////////////////////
// Memory access with pending latch and timer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_access_exec
   import mem_bus_pkg::*, mem_store_pkg::*;
#(
   parameter int mem_latency = 4,
   parameter int bank_rows   = 64
)
(
   input  logic    bus_clk,
   input  logic    rst,
   mem_req_if.dst  req,
   mem_line_if.src line
);

   localparam int timer_w  = $clog2(mem_latency + 1);
   localparam int row_w    = $clog2(bank_rows);
   localparam int half_bit = byte_off_w;
   localparam int line_w   = $bits(mem_line_t);

   bus_req_t              pend_req;
   mem_line_t             pend_data;
   logic                  pend_valid;
   logic                  rd_ready;
   logic [timer_w-1:0]    timer;
   logic                  access_last;
   logic [line_bytes-1:0] size_mask;
   logic [line_bytes-1:0] line_en;
   mem_line_t             shifted;
   logic [row_w-1:0]      row_addr;
   byte_en_t              byte_en;
   mem_row_t              wdata;
   mem_row_t              rdata;

   assign req.take    = !pend_valid;
   assign access_last = pend_valid && !rd_ready && (timer == timer_w'(mem_latency));

   ////////////////////////////////////////////////////////////////////////////
   // Pending latch and memory timer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         pend_valid <= 1'b0;
         rd_ready   <= 1'b0;
         timer      <= '0;
      end
      else
      begin
         // Timer starts at one in the first access cycle
         if (req.valid && req.take)
         begin
            pend_valid <= 1'b1;
            timer      <= timer_w'(1);
         end
         else if (pend_valid && !rd_ready && (timer != timer_w'(mem_latency)))
            timer <= timer + 1'b1;
         if (access_last)
         begin
            if (pend_req.rw)
               pend_valid <= 1'b0;
            else
               rd_ready <= 1'b1;
         end
         // Read line handed to the reply stage
         if (line.valid && line.take)
         begin
            pend_valid <= 1'b0;
            rd_ready   <= 1'b0;
         end
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (req.valid && req.take)
      begin
         pend_req  <= req.req;
         pend_data <= req.data;
      end
   end

   // Write data moves up by the byte offset, size+1 bytes are enabled
   always_comb
   begin
      size_mask = '0;
      for (int i = 0; i < max_wr_bytes; i++)
         size_mask[i] = (i <= int'(pend_req.size));
      line_en = size_mask << pend_req.addr[byte_off_w-1:0];
      shifted = pend_data << {pend_req.addr[byte_off_w-1:0], 3'b000};
   end

   assign byte_en  = pend_req.addr[half_bit] ? {line_en, {line_bytes{1'b0}}}
                                             : {{line_bytes{1'b0}}, line_en};
   assign wdata    = {shifted, shifted};
   assign row_addr = pend_req.addr[half_bit+1 +: row_w];

   mem_bank #(
      .bank_rows (bank_rows)
   ) mem_bank_i (
      .bus_clk  (bus_clk),
      .en       (access_last),
      .wr       (pend_req.rw),
      .row_addr (row_addr),
      .byte_en  (byte_en),
      .wdata    (wdata),
      .rdata    (rdata)
   );

   // Read side, half of the row picked by address bit 4
   assign line.valid    = rd_ready;
   assign line.line     = rdata[pend_req.addr[half_bit]*line_w +: line_w];
   assign line.src_code = pend_req.src;

endmodule

//--- source/mem_bank.sv
////////////////////////////////////////////////////////////////////////////
// Row storage with byte enables
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_bank
   import mem_store_pkg::*;
#(
   parameter int bank_rows = 64
)
(
   input  logic                         bus_clk,
   input  logic                         en,
   input  logic                         wr,
   input  logic [$clog2(bank_rows)-1:0] row_addr,
   input  byte_en_t                     byte_en,
   input  mem_row_t                     wdata,
   output mem_row_t                     rdata
);

   mem_row_t mem [bank_rows];

   // Read data registered, held until the next read
   always_ff @(posedge bus_clk)
   begin
      if (en)
      begin
         if (wr)
         begin
            for (int b = 0; b < row_bytes; b++)
            begin
               if (byte_en[b])
                  mem[row_addr][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
         else
            rdata <= mem[row_addr];
      end
   end

endmodule

//--- source/mem_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// System bus encodings
////////////////////////////////////////////////////////////////////////////

package mem_bus_pkg;

   // Requester codes, also used to pick the destination strobe
   typedef enum logic [1:0]
   {
      src_ic  = 2'd0,
      src_dc  = 2'd1,
      src_dma = 2'd2
   } bus_src_t;

   // One data beat on the bus
   typedef logic [31:0] bus_word_t;

   // A line travels as four beats, lowest word first
   localparam int line_beats = 4;

   // Largest write the bus can issue in one request
   localparam int max_wr_bytes = 8;

   // Request as captured from the bus
   // size is bytes minus one, rw high for a write
   typedef struct packed
   {
      logic [15:0]                     addr;
      logic [$clog2(max_wr_bytes)-1:0] size;
      logic                            rw;
      bus_src_t                        src;
   } bus_req_t;

endpackage

//--- source/mem_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Memory module bus controller
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_ctrl
   import mem_bus_pkg::*;
#(
   parameter int mem_latency = 4,
   parameter int bank_rows   = 64
)
(
   input  logic        bus_clk,
   input  logic        rst,
   // Request side of the bus
   input  logic        req_valid,
   input  logic [15:0] req_addr,
   input  logic [2:0]  req_size,
   input  logic        req_rw,
   input  bus_src_t    req_src,
   input  logic        wr_valid,
   input  bus_word_t   wr_data,
   input  logic        bg,
   output logic        ack,
   // Return side
   output logic        br,
   output logic        dest_ic,
   output logic        dest_dc,
   output logic        rd_valid,
   output bus_word_t   rd_data
);

   mem_req_if  req_i ();
   mem_line_if line_i ();

   bus_req_decode bus_req_decode_i (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_size  (req_size),
      .req_rw    (req_rw),
      .req_src   (req_src),
      .wr_valid  (wr_valid),
      .wr_data   (wr_data),
      .ack       (ack),
      .req       (req_i.src)
   );

   mem_access_exec #(
      .mem_latency (mem_latency),
      .bank_rows   (bank_rows)
   ) mem_access_exec_i (
      .bus_clk (bus_clk),
      .rst     (rst),
      .req     (req_i.dst),
      .line    (line_i.src)
   );

   bus_reply_result bus_reply_result_i (
      .bus_clk  (bus_clk),
      .rst      (rst),
      .line     (line_i.dst),
      .bg       (bg),
      .br       (br),
      .dest_ic  (dest_ic),
      .dest_dc  (dest_dc),
      .rd_valid (rd_valid),
      .rd_data  (rd_data)
   );

endmodule

//--- source/mem_ctrl_if.sv
////////////////////////////////////////////////////////////////////////////
// Controller stage handshakes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

// Decode to execute, carries the write latch contents
interface mem_req_if
   import mem_bus_pkg::*, mem_store_pkg::*;
();

   logic      valid;
   bus_req_t  req;
   mem_line_t data;
   logic      take;

   modport src
   (
      output valid, req, data,
      input  take
   );

   modport dst
   (
      input  valid, req, data,
      output take
   );

endinterface

// Execute to result, carries a read line and who asked for it
interface mem_line_if
   import mem_bus_pkg::*, mem_store_pkg::*;
();

   logic      valid;
   mem_line_t line;
   bus_src_t  src_code;
   logic      take;

   modport src
   (
      output valid, line, src_code,
      input  take
   );

   modport dst
   (
      input  valid, line, src_code,
      output take
   );

endinterface

//--- source/mem_store_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Memory bank geometry
////////////////////////////////////////////////////////////////////////////

package mem_store_pkg;

   // Bytes in one bus line and in one bank row
   localparam int line_bytes = 16;
   localparam int row_bytes  = 32;

   // Byte offset inside a line, taken from the low address bits
   localparam int byte_off_w = 4;

   // A line is half of a row, address bit 4 picks the half
   typedef logic [8*line_bytes-1:0] mem_line_t;
   typedef logic [8*row_bytes-1:0]  mem_row_t;

   // One enable per row byte
   typedef logic [row_bytes-1:0] byte_en_t;

endpackage
